//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_bpu
FLIST = bpu_top.f
LOG   = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- bpu_top.f
hdl/bpu_pkg.sv
hdl/bp_lookup_if.sv
hdl/inst_decode.sv
hdl/tage_predictor.sv
hdl/target_buffer.sv
hdl/return_stack.sv
hdl/pred_result.sv
hdl/bpu_top.sv
testbench/bpu_sva.sv
testbench/tb_bpu.sv

//--- hdl/bp_lookup_if.sv
interface bp_lookup_if import bpu_pkg::*; ();

    // decoded lookup
    logic            valid;
    logic [xlen-1:0] pc;
    logic [1:0]      cls;
    logic            is_ret;
    logic [xlen-1:0] imm;

    // answers from the predictor structures, same cycle
    logic            dir_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;
    logic            ras_valid;
    logic [xlen-1:0] ras_top;

    modport decode (output valid, pc, cls, is_ret, imm);

    modport execute (
        input  valid, pc, cls, is_ret, imm,
        output dir_taken, btb_hit, btb_target, ras_valid, ras_top
    );

endinterface

//--- hdl/bpu_pkg.sv
package bpu_pkg;

    // datapath and history
    localparam int xlen          = 32;
    localparam int hist_len      = 10;

    // table geometry
    localparam int bim_entries   = 64;   // indexed by pc[7:2]
    localparam int bim_idx_width = 6;
    localparam int tag_entries   = 32;   // per tagged table
    localparam int tag_idx_width = 5;
    localparam int tag_width     = 6;
    localparam int btb_entries   = 32;   // indexed by pc[6:2]
    localparam int btb_idx_width = 5;
    localparam int btb_tag_width = 25;   // pc[31:7]

    // return stack, pointer is one bit wider than the slot index
    localparam int ras_depth     = 8;
    localparam int ras_ptr_width = 4;

    // rv32i control transfer opcodes
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // instruction classes
    localparam logic [1:0] cls_none = 2'b00;
    localparam logic [1:0] cls_cond = 2'b01;
    localparam logic [1:0] cls_jal  = 2'b10;
    localparam logic [1:0] cls_jalr = 2'b11;
    localparam logic [1:0] cls_ret  = 2'b11;  // shares jalr code, is_ret flag tells it apart

    // 2-bit saturating counter states
    localparam logic [1:0] ctr_strong_nt = 2'b00;
    localparam logic [1:0] ctr_weak_nt   = 2'b01;
    localparam logic [1:0] ctr_weak_t    = 2'b10;
    localparam logic [1:0] ctr_strong_t  = 2'b11;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    // one fetched word, viewed as B-type or J-type
    typedef union packed {
        b_fields_t b;
        j_fields_t j;
    } inst_word_u;

endpackage

//--- hdl/bpu_top.sv
module bpu_top import bpu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // fetch lookup
    input  logic                lookup_valid_i,
    input  logic [xlen-1:0]     lookup_pc_i,
    input  logic [xlen-1:0]     lookup_inst_i,
    // resolved branch report
    input  logic                update_valid_i,
    input  logic [xlen-1:0]     update_pc_i,
    input  logic                update_taken_i,
    input  logic                update_correct_i,
    input  logic [xlen-1:0]     update_target_i,
    input  logic [hist_len-1:0] update_history_i,
    // call and return events
    input  logic                call_push_i,
    input  logic [xlen-1:0]     call_addr_i,
    input  logic                ret_pop_i,
    // registered prediction
    output logic                pred_valid_o,
    output logic                pred_branch_o,
    output logic                pred_taken_o,
    output logic [xlen-1:0]     pred_target_o,
    output logic [hist_len-1:0] history_o
);

    bp_lookup_if lk ();

    inst_decode u_decode (
        .lookup_valid_i (lookup_valid_i),
        .lookup_pc_i    (lookup_pc_i),
        .lookup_inst_i  (lookup_inst_i),
        .lk             (lk)
    );

    tage_predictor u_tage (
        .clk              (clk),
        .rst              (rst),
        .lk               (lk),
        .update_valid_i   (update_valid_i),
        .update_pc_i      (update_pc_i),
        .update_taken_i   (update_taken_i),
        .update_correct_i (update_correct_i),
        .update_history_i (update_history_i),
        .history_o        (history_o)
    );

    target_buffer u_btb (
        .clk             (clk),
        .rst             (rst),
        .lk              (lk),
        .update_valid_i  (update_valid_i),
        .update_pc_i     (update_pc_i),
        .update_taken_i  (update_taken_i),
        .update_target_i (update_target_i)
    );

    return_stack u_ras (
        .clk         (clk),
        .rst         (rst),
        .lk          (lk),
        .call_push_i (call_push_i),
        .call_addr_i (call_addr_i),
        .ret_pop_i   (ret_pop_i)
    );

    pred_result u_result (
        .clk           (clk),
        .rst           (rst),
        .lk            (lk),
        .pred_valid_o  (pred_valid_o),
        .pred_branch_o (pred_branch_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

endmodule

//--- hdl/inst_decode.sv
module inst_decode import bpu_pkg::*; (
    input  logic            lookup_valid_i,
    input  logic [xlen-1:0] lookup_pc_i,
    input  inst_word_u      lookup_inst_i,
    bp_lookup_if.decode     lk
);

    logic rd_zero;
    logic rs1_link;
    logic i_imm_zero;

    assign lk.valid = lookup_valid_i;
    assign lk.pc    = lookup_pc_i;

    // return pattern is jalr x0, 0(ra) or jalr x0, 0(t0)
    assign rd_zero    = (lookup_inst_i.j.rd == 5'd0);
    assign rs1_link   = (lookup_inst_i.b.rs1 == 5'd1) || (lookup_inst_i.b.rs1 == 5'd5);
    assign i_imm_zero = ({lookup_inst_i.b.imm12, lookup_inst_i.b.imm10_5,
                          lookup_inst_i.b.rs2} == 12'd0);  // I-type imm sits in [31:20]

    always_comb begin
        lk.cls    = cls_none;
        lk.is_ret = 1'b0;
        lk.imm    = '0;
        case (lookup_inst_i.b.opcode)
            op_branch: begin
                lk.cls = cls_cond;
                lk.imm = {{20{lookup_inst_i.b.imm12}}, lookup_inst_i.b.imm11,
                          lookup_inst_i.b.imm10_5, lookup_inst_i.b.imm4_1, 1'b0};
            end
            op_jal: begin
                lk.cls = cls_jal;
                lk.imm = {{12{lookup_inst_i.j.imm20}}, lookup_inst_i.j.imm19_12,
                          lookup_inst_i.j.imm11, lookup_inst_i.j.imm10_1, 1'b0};
            end
            op_jalr: begin
                lk.cls    = cls_jalr;  // target comes from btb or ras only
                lk.is_ret = rd_zero && rs1_link && i_imm_zero;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/pred_result.sv
module pred_result import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    bp_lookup_if.execute    lk,
    output logic            pred_valid_o,
    output logic            pred_branch_o,
    output logic            pred_taken_o,
    output logic [xlen-1:0] pred_target_o
);

    logic            nxt_taken;
    logic [xlen-1:0] nxt_target;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] rel_target;

    assign seq_pc     = lk.pc + xlen'(4);
    assign rel_target = lk.btb_hit ? lk.btb_target : lk.pc + lk.imm;  // btb first

    always_comb begin
        nxt_taken  = 1'b0;
        nxt_target = seq_pc;
        if (lk.cls == cls_ret && lk.is_ret) begin
            nxt_taken  = lk.ras_valid;
            nxt_target = lk.ras_valid ? lk.ras_top : seq_pc;
        end else begin
            case (lk.cls)
                cls_jal: begin
                    nxt_taken  = 1'b1;
                    nxt_target = rel_target;
                end
                cls_jalr: begin
                    nxt_taken  = lk.btb_hit;   // no usable imm for jalr
                    nxt_target = lk.btb_hit ? lk.btb_target : seq_pc;
                end
                cls_cond: begin
                    nxt_taken  = lk.dir_taken;
                    nxt_target = lk.dir_taken ? rel_target : seq_pc;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid_o  <= 1'b0;
            pred_branch_o <= 1'b0;
            pred_taken_o  <= 1'b0;
        end else begin
            pred_valid_o  <= lk.valid;
            pred_branch_o <= lk.valid && (lk.cls != cls_none);
            pred_taken_o  <= lk.valid && nxt_taken;
        end
    end

    // target held between lookups
    always_ff @(posedge clk) begin
        if (lk.valid)
            pred_target_o <= nxt_target;
    end

endmodule

//--- hdl/return_stack.sv
module return_stack import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    bp_lookup_if.execute    lk,
    input  logic            call_push_i,
    input  logic [xlen-1:0] call_addr_i,
    input  logic            ret_pop_i
);

    logic [xlen-1:0]          stack_q [ras_depth];
    logic [ras_ptr_width-1:0] sp_q;    // next free slot
    logic [ras_ptr_width-1:0] sp_pop;
    logic [ras_ptr_width-1:0] sp_nxt;
    logic [ras_ptr_width-2:0] top_idx;
    logic                     do_push;

    assign top_idx      = sp_q[ras_ptr_width-2:0] - 1'b1;
    assign lk.ras_valid = (sp_q != '0);
    assign lk.ras_top   = stack_q[top_idx];

    // pop first, then push into the freed or next slot
    always_comb begin
        sp_pop = sp_q;
        if (ret_pop_i && sp_q != '0)
            sp_pop = sp_q - 1'b1;   // empty stack ignores the pop
        do_push = call_push_i && (sp_pop < ras_ptr_width'(ras_depth));
        sp_nxt  = do_push ? sp_pop + 1'b1 : sp_pop;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp_q <= '0;
        else
            sp_q <= sp_nxt;
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack_q[sp_pop[ras_ptr_width-2:0]] <= call_addr_i;
    end

endmodule

//--- hdl/tage_predictor.sv
module tage_predictor import bpu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    bp_lookup_if.execute        lk,
    input  logic                update_valid_i,
    input  logic [xlen-1:0]     update_pc_i,
    input  logic                update_taken_i,
    input  logic                update_correct_i,
    input  logic [hist_len-1:0] update_history_i,
    output logic [hist_len-1:0] history_o
);

    // T0 folds the short end of history into its index
    function automatic logic [tag_idx_width-1:0] t0_index(input logic [xlen-1:0] pc,
                                                          input logic [hist_len-1:0] h);
        return pc[6:2] ^ h[4:0];
    endfunction

    function automatic logic [tag_width-1:0] t0_tag_of(input logic [xlen-1:0] pc,
                                                       input logic [hist_len-1:0] h);
        return pc[12:7] ^ h[9:4];
    endfunction

    function automatic logic [tag_idx_width-1:0] t1_index(input logic [xlen-1:0] pc,
                                                          input logic [hist_len-1:0] h);
        return pc[6:2] ^ h[9:5];
    endfunction

    function automatic logic [tag_width-1:0] t1_tag_of(input logic [xlen-1:0] pc,
                                                       input logic [hist_len-1:0] h);
        return pc[12:7] ^ h[5:0];
    endfunction

    function automatic logic [1:0] sat_ctr(input logic [1:0] c, input logic up);
        if (up)
            return (c == ctr_strong_t) ? c : c + 2'd1;
        return (c == ctr_strong_nt) ? c : c - 2'd1;
    endfunction

    logic [hist_len-1:0]  hist_q;
    logic [1:0]           bim_ctr  [bim_entries];
    logic                 t0_valid [tag_entries];
    logic [tag_width-1:0] t0_tag   [tag_entries];
    logic [1:0]           t0_ctr   [tag_entries];
    logic                 t1_valid [tag_entries];
    logic [tag_width-1:0] t1_tag   [tag_entries];
    logic [1:0]           t1_ctr   [tag_entries];

    logic [tag_idx_width-1:0] t0_idx;
    logic [tag_idx_width-1:0] t1_idx;
    logic                     t0_hit;
    logic                     t1_hit;
    logic [bim_idx_width-1:0] u_bim_idx;
    logic [tag_idx_width-1:0] u_t0_idx;
    logic [tag_idx_width-1:0] u_t1_idx;
    logic [tag_width-1:0]     u_t0_tag;
    logic [tag_width-1:0]     u_t1_tag;
    logic                     u_t0_hit;
    logic                     u_t1_hit;

    // lookup against current history
    assign t0_idx = t0_index(lk.pc, hist_q);
    assign t1_idx = t1_index(lk.pc, hist_q);
    assign t0_hit = t0_valid[t0_idx] && (t0_tag[t0_idx] == t0_tag_of(lk.pc, hist_q));
    assign t1_hit = t1_valid[t1_idx] && (t1_tag[t1_idx] == t1_tag_of(lk.pc, hist_q));

    assign lk.dir_taken = t1_hit ? t1_ctr[t1_idx][1] :
                          t0_hit ? t0_ctr[t0_idx][1] : bim_ctr[lk.pc[7:2]][1];

    // provider recomputed from the history the branch was predicted with
    assign u_bim_idx = update_pc_i[7:2];
    assign u_t0_idx  = t0_index(update_pc_i, update_history_i);
    assign u_t1_idx  = t1_index(update_pc_i, update_history_i);
    assign u_t0_tag  = t0_tag_of(update_pc_i, update_history_i);
    assign u_t1_tag  = t1_tag_of(update_pc_i, update_history_i);
    assign u_t0_hit  = t0_valid[u_t0_idx] && (t0_tag[u_t0_idx] == u_t0_tag);
    assign u_t1_hit  = t1_valid[u_t1_idx] && (t1_tag[u_t1_idx] == u_t1_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
            for (int i = 0; i < bim_entries; i++)
                bim_ctr[i] <= ctr_weak_nt;
            for (int i = 0; i < tag_entries; i++) begin
                t0_valid[i] <= 1'b0;
                t0_tag[i]   <= '0;
                t0_ctr[i]   <= ctr_weak_nt;
                t1_valid[i] <= 1'b0;
                t1_tag[i]   <= '0;
                t1_ctr[i]   <= ctr_weak_nt;
            end
        end else if (update_valid_i) begin
            hist_q             <= {hist_q[hist_len-2:0], update_taken_i};
            bim_ctr[u_bim_idx] <= sat_ctr(bim_ctr[u_bim_idx], update_taken_i);
            if (u_t1_hit) begin
                t1_ctr[u_t1_idx] <= update_correct_i ? sat_ctr(t1_ctr[u_t1_idx], update_taken_i)
                                  : (update_taken_i ? ctr_strong_t : ctr_strong_nt);
            end else if (u_t0_hit) begin
                t0_ctr[u_t0_idx] <= update_correct_i ? sat_ctr(t0_ctr[u_t0_idx], update_taken_i)
                                  : (update_taken_i ? ctr_strong_t : ctr_strong_nt);
            end else if (!update_correct_i) begin
                // bimodal mispredicted so claim a tagged entry
                if (!t1_valid[u_t1_idx]) begin   // free T1 slot first
                    t1_valid[u_t1_idx] <= 1'b1;
                    t1_tag[u_t1_idx]   <= u_t1_tag;
                    t1_ctr[u_t1_idx]   <= update_taken_i ? ctr_weak_t : ctr_weak_nt;
                end else begin
                    t0_valid[u_t0_idx] <= 1'b1;
                    t0_tag[u_t0_idx]   <= u_t0_tag;
                    t0_ctr[u_t0_idx]   <= update_taken_i ? ctr_weak_t : ctr_weak_nt;
                end
            end
        end
    end

    assign history_o = hist_q;

endmodule

//--- hdl/target_buffer.sv
module target_buffer import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    bp_lookup_if.execute    lk,
    input  logic            update_valid_i,
    input  logic [xlen-1:0] update_pc_i,
    input  logic            update_taken_i,
    input  logic [xlen-1:0] update_target_i
);

    logic                     btb_valid  [btb_entries];
    logic [btb_tag_width-1:0] btb_tag    [btb_entries];
    logic [xlen-1:0]          btb_target [btb_entries];

    logic [btb_idx_width-1:0] rd_idx;
    logic [btb_idx_width-1:0] wr_idx;
    logic                     wr_en;

    // read side, direct mapped
    assign rd_idx = lk.pc[6:2];

    assign lk.btb_hit    = btb_valid[rd_idx] && (btb_tag[rd_idx] == lk.pc[31:7]);
    assign lk.btb_target = btb_target[rd_idx];

    // only taken transfers get an entry
    assign wr_idx = update_pc_i[6:2];
    assign wr_en  = update_valid_i && update_taken_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++)
                btb_valid[i] <= 1'b0;
        end else if (wr_en) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target qualified by the valid bit
    always_ff @(posedge clk) begin
        if (wr_en) begin
            btb_tag[wr_idx]    <= update_pc_i[31:7];
            btb_target[wr_idx] <= update_target_i;
        end
    end

endmodule

//--- testbench/bpu_sva.sv
module bpu_sva (
    input logic clk,
    input logic rst,
    input logic lookup_valid_i,
    input logic pred_valid_o,
    input logic pred_branch_o,
    input logic pred_taken_o
);

    // registered lookup, one cycle to the prediction
    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
        lookup_valid_i |=> pred_valid_o)
        else $error("pred_valid_o did not follow lookup_valid_i");

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        !lookup_valid_i |=> !pred_valid_o)
        else $error("pred_valid_o raised without a lookup");

    a_taken_branch: assert property (@(posedge clk) pred_taken_o |-> pred_branch_o)
        else $error("pred_taken_o without pred_branch_o");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !pred_valid_o && !pred_branch_o && !pred_taken_o)
        else $error("prediction outputs active during reset");

endmodule

bind bpu_top bpu_sva u_sva (
    .clk            (clk),
    .rst            (rst),
    .lookup_valid_i (lookup_valid_i),
    .pred_valid_o   (pred_valid_o),
    .pred_branch_o  (pred_branch_o),
    .pred_taken_o   (pred_taken_o)
);

//--- testbench/tb_bpu.sv
module tb_bpu import bpu_pkg::*; ();

    localparam int cond_iters = 150;
    // reset, six tests with two drain cycles each, and a margin
    localparam int run_limit  = 10 + 8 + 12 + 2 * cond_iters + 27 + 4 + 6 + 6 * 2 + 40;

    typedef struct {
        logic            branch;
        logic            taken;
        logic [xlen-1:0] target;
        int              cyc;
    } exp_t;

    logic clk, rst;
    logic lookup_valid_i, update_valid_i, update_taken_i, update_correct_i;
    logic call_push_i, ret_pop_i;
    logic [xlen-1:0] lookup_pc_i, lookup_inst_i, update_pc_i, update_target_i, call_addr_i;
    logic [hist_len-1:0] update_history_i;
    logic pred_valid_o, pred_branch_o, pred_taken_o;
    logic [xlen-1:0] pred_target_o;
    logic [hist_len-1:0] history_o;

    // reference state
    logic [1:0]               m_bim [bim_entries];
    logic                     m_t0_v [tag_entries], m_t1_v [tag_entries];
    logic [tag_width-1:0]     m_t0_tag [tag_entries], m_t1_tag [tag_entries];
    logic [1:0]               m_t0_ctr [tag_entries], m_t1_ctr [tag_entries];
    logic                     m_btb_v [btb_entries];
    logic [btb_tag_width-1:0] m_btb_tag [btb_entries];
    logic [xlen-1:0]          m_btb_tgt [btb_entries];
    logic [xlen-1:0]          m_ras [ras_depth];
    int                       m_sp;
    logic [hist_len-1:0]      m_hist;

    exp_t        exp_q[$];
    exp_t        front_e;
    logic [31:0] lfsr_q = 32'h20b3;
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_err0 = 0;

    bpu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc > run_limit) begin
            $display("timeout, run exceeded %0d cycles", run_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [xlen-1:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [xlen-1:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [1:0] sat(input logic [1:0] c, input logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'd1;
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // direction from the longest-history table that matches
    function automatic logic model_dir(input logic [xlen-1:0] pc, input logic [hist_len-1:0] h);
        logic [4:0] i0, i1;
        i0 = pc[6:2] ^ h[4:0];
        i1 = pc[6:2] ^ h[9:5];
        if (m_t1_v[i1] && m_t1_tag[i1] == (pc[12:7] ^ h[5:0]))
            return m_t1_ctr[i1][1];
        if (m_t0_v[i0] && m_t0_tag[i0] == (pc[12:7] ^ h[9:4]))
            return m_t0_ctr[i0][1];
        return m_bim[pc[7:2]][1];
    endfunction

    // reference prediction for one lookup against current model state
    function automatic exp_t expected_pred(input logic [xlen-1:0] pc, input logic [xlen-1:0] inst);
        exp_t            e;
        logic [6:0]      op;
        logic [xlen-1:0] imm_b, imm_j;
        logic            hit, is_ret;
        op     = inst[6:0];
        imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        hit    = m_btb_v[pc[6:2]] && (m_btb_tag[pc[6:2]] == pc[31:7]);
        is_ret = (inst[11:7] == 5'd0) && (inst[19:15] == 5'd1 || inst[19:15] == 5'd5)
                 && (inst[31:20] == 12'd0);
        e.branch = (op == 7'b1100011) || (op == 7'b1101111) || (op == 7'b1100111);
        e.taken  = 1'b0;
        e.target = pc + 32'd4;
        e.cyc    = 0;
        if (op == 7'b1101111) begin
            e.taken  = 1'b1;
            e.target = hit ? m_btb_tgt[pc[6:2]] : pc + imm_j;
        end else if (op == 7'b1100111 && is_ret) begin
            if (m_sp > 0) begin
                e.taken  = 1'b1;
                e.target = m_ras[m_sp-1];
            end
        end else if (op == 7'b1100111) begin
            if (hit) begin
                e.taken  = 1'b1;
                e.target = m_btb_tgt[pc[6:2]];
            end
        end else if (op == 7'b1100011 && model_dir(pc, m_hist)) begin
            e.taken  = 1'b1;
            e.target = hit ? m_btb_tgt[pc[6:2]] : pc + imm_b;
        end
        return e;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < bim_entries; i++)
            m_bim[i] = 2'b01;
        for (int i = 0; i < tag_entries; i++) begin
            m_t0_v[i] = 1'b0;
            m_t1_v[i] = 1'b0;
            m_t0_ctr[i] = 2'b01;
            m_t1_ctr[i] = 2'b01;
        end
        for (int i = 0; i < btb_entries; i++)
            m_btb_v[i] = 1'b0;
        m_sp = 0;
        m_hist = '0;
    endtask

    task automatic model_update(input logic [xlen-1:0] pc, input logic taken, input logic correct,
                                input logic [xlen-1:0] target);
        logic [4:0] i0, i1;
        logic [5:0] g0, g1;
        logic       hit0, hit1;
        i0 = pc[6:2] ^ m_hist[4:0];
        i1 = pc[6:2] ^ m_hist[9:5];
        g0 = pc[12:7] ^ m_hist[9:4];
        g1 = pc[12:7] ^ m_hist[5:0];
        hit0 = m_t0_v[i0] && m_t0_tag[i0] == g0;
        hit1 = m_t1_v[i1] && m_t1_tag[i1] == g1;
        m_bim[pc[7:2]] = sat(m_bim[pc[7:2]], taken);
        if (hit1)
            m_t1_ctr[i1] = correct ? sat(m_t1_ctr[i1], taken) : {taken, taken};
        else if (hit0)
            m_t0_ctr[i0] = correct ? sat(m_t0_ctr[i0], taken) : {taken, taken};
        else if (!correct) begin  // bimodal was the provider here
            if (!m_t1_v[i1]) begin
                m_t1_v[i1] = 1'b1;
                m_t1_tag[i1] = g1;
                m_t1_ctr[i1] = taken ? 2'b10 : 2'b01;
            end else begin
                m_t0_v[i0] = 1'b1;
                m_t0_tag[i0] = g0;
                m_t0_ctr[i0] = taken ? 2'b10 : 2'b01;
            end
        end
        if (taken) begin
            m_btb_v[pc[6:2]] = 1'b1;
            m_btb_tag[pc[6:2]] = pc[31:7];
            m_btb_tgt[pc[6:2]] = target;
        end
        m_hist = {m_hist[hist_len-2:0], taken};
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_target(input string name, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_history(input string name, input logic [hist_len-1:0] got,
                                 input logic [hist_len-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // outputs settle after the rising edge and are compared at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            while (exp_q.size() > 0 && exp_q[0].cyc + 1 < cyc) begin
                errors++;
                $display("no pred_valid_o for the lookup driven in cycle %0d", exp_q[0].cyc);
                void'(exp_q.pop_front());
            end
            if (pred_valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("pred_valid_o high with no lookup outstanding at t=%0t", $time);
                end else begin
                    front_e = exp_q.pop_front();
                    check_flag("pred_branch_o", pred_branch_o, front_e.branch);
                    check_flag("pred_taken_o", pred_taken_o, front_e.taken);
                    check_target("pred_target_o", pred_target_o, front_e.target);
                end
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
        lookup_valid_i = 1'b0;
        update_valid_i = 1'b0;
        call_push_i    = 1'b0;
        ret_pop_i      = 1'b0;
    endtask

    task automatic lookup(input logic [xlen-1:0] pc, input logic [xlen-1:0] inst);
        exp_t e;
        e = expected_pred(pc, inst);  // same-edge updates not yet visible
        e.cyc = cyc;
        exp_q.push_back(e);
        lookup_valid_i = 1'b1;
        lookup_pc_i    = pc;
        lookup_inst_i  = inst;
    endtask

    task automatic update(input logic [xlen-1:0] pc, input logic taken,
                          input logic [xlen-1:0] target);
        logic correct;
        correct = (model_dir(pc, m_hist) == taken);
        update_valid_i   = 1'b1;
        update_pc_i      = pc;
        update_taken_i   = taken;
        update_correct_i = correct;
        update_target_i  = target;
        update_history_i = m_hist;
        model_update(pc, taken, correct, target);
    endtask

    task automatic ras_op(input logic push, input logic [xlen-1:0] addr, input logic pop);
        call_push_i = push;
        call_addr_i = addr;
        ret_pop_i   = pop;
        if (pop && m_sp > 0)
            m_sp--;
        if (push && m_sp < ras_depth) begin
            m_ras[m_sp] = addr;
            m_sp++;
        end
    endtask

    task automatic finish_test(input string name);
        tick();
        tick();
        $display("test %s %s, %0d errors", name, (errors == test_err0) ? "ok" : "failed",
                 errors - test_err0);
        test_err0 = errors;
    endtask

    task automatic test_nonbranch();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(25);
            lookup(rand_bits(30) << 2, {r[24:0], 7'b0110011});
            tick();
        end
        finish_test("non-branch");
    endtask

    task automatic test_jal();
        logic [xlen-1:0] pc, inst, tgt;
        logic [31:0]     r;
        for (int i = 0; i < 4; i++) begin
            pc   = rand_bits(30) << 2;
            r    = rand_bits(20);
            inst = enc_jal({r[19:0], 1'b0});
            tgt  = 32'h8000_0000 | (rand_bits(16) << 2);
            lookup(pc, inst);
            tick();
            update(pc, 1'b1, tgt);
            tick();
            lookup(pc, inst);   // now from the btb
            tick();
        end
        finish_test("jal");
    endtask

    task automatic test_cond();
        logic [xlen-1:0] pc;
        logic [31:0]     r;
        logic [12:0]     imm;
        logic            taken;
        check_history("history_o", history_o, m_hist);
        for (int i = 0; i < cond_iters; i++) begin
            pc  = 32'h0000_1000 | (rand_bits(3) << 2) | (rand_bits(2) << 7);
            r   = rand_bits(12);
            imm = {r[11:0], 1'b0};
            lookup(pc, enc_branch(imm));
            tick();
            taken = (rand_bits(2) != 32'd0) ^ pc[7];  // biased per pc
            update(pc, taken, pc + {{19{imm[12]}}, imm});
            tick();
            check_history("history_o", history_o, m_hist);
        end
        finish_test("conditional");
    endtask

    task automatic test_ras();
        logic [xlen-1:0] ret_inst;
        ret_inst = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
        lookup(32'h0000_4000, ret_inst);  // empty stack
        tick();
        for (int i = 0; i < 9; i++) begin
            ras_op(1'b1, rand_bits(30) << 2, 1'b0);
            tick();
        end
        lookup(32'h0000_4000, ret_inst);
        tick();
        for (int i = 0; i < 8; i++) begin
            ras_op(1'b0, '0, 1'b1);
            tick();
            lookup(32'h0000_4000, ret_inst);
            tick();
        end
        finish_test("return");
    endtask

    task automatic test_jalr();
        logic [xlen-1:0] pc;
        pc = rand_bits(30) << 2;
        lookup(pc, {12'h010, 5'd6, 3'b000, 5'd1, 7'b1100111});
        tick();
        update(pc, 1'b1, 32'h9000_0000 | (rand_bits(16) << 2));
        tick();
        lookup(pc, {12'h010, 5'd6, 3'b000, 5'd1, 7'b1100111});
        tick();
        lookup(pc + 32'd4, {12'h004, 5'd1, 3'b000, 5'd0, 7'b1100111});  // nonzero offset
        tick();
        finish_test("jalr");
    endtask

    task automatic test_pop_push();
        logic [xlen-1:0] ret_inst;
        ret_inst = {12'd0, 5'd5, 3'b000, 5'd0, 7'b1100111};
        ras_op(1'b1, rand_bits(30) << 2, 1'b0);
        tick();
        ras_op(1'b1, rand_bits(30) << 2, 1'b0);
        tick();
        ras_op(1'b1, rand_bits(30) << 2, 1'b1);
        tick();
        lookup(32'h0000_5000, ret_inst);
        tick();
        ras_op(1'b0, '0, 1'b1);
        tick();
        lookup(32'h0000_5000, ret_inst);
        tick();
        finish_test("pop-push");
    endtask

    initial begin
        rst              = 1'b1;
        lookup_valid_i   = 1'b0;
        lookup_pc_i      = '0;
        lookup_inst_i    = '0;
        update_valid_i   = 1'b0;
        update_pc_i      = '0;
        update_taken_i   = 1'b0;
        update_correct_i = 1'b0;
        update_target_i  = '0;
        update_history_i = '0;
        call_push_i      = 1'b0;
        call_addr_i      = '0;
        ret_pop_i        = 1'b0;
        model_reset();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        test_nonbranch();
        test_jal();
        test_cond();
        test_ras();
        test_jalr();
        test_pop_push();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
